// File: list.f
verilog/sys_glue_pkg.sv
verilog/cpu_bus_decode.sv
verilog/xmem_map.sv
verilog/cpu_ready.sv
verilog/key_matrix.sv
verilog/sys_glue.sv
verification/tb_clock.sv
verification/sys_glue_assert.sv
verification/sys_glue_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the glue logic testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module sys_glue_tb -o sim_glue \
  && ./obj_dir/sim_glue > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation FAILED" sim.log && { echo "Run failed"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "Run did not complete"; exit 1; }
echo "Run passed"

// File: verification/sys_glue_tb.sv
/*
 * Testbench for the glue top level: random CPU bus accesses against a
 * reference memory map, cartridge banking, loader register space,
 * 9901 pins and CPU ready
 */
`default_nettype none

module sys_glue_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import sys_glue_pkg::*;

  localparam logic [2:0] cart_base  = 3'd5;  // Non-default base checks the parameter path
  localparam int         max_cycles = 4000;  // Stimulus runs roughly 1500 cycles

  typedef struct packed {
    chip_sel_t sel;
    xaddr_t    xaddr;
  } map_t;

  logic        clk, cpu_reset, rd_i, wr_i, ready_o, vdp_wr_o, vdp_int_i, core_reset_o;
  logic        mem_rd_ack_i, mem_wr_ack_i, vdp_rd_ack_i, vdp_wr_ack_i;
  logic        mem_rd_rq_o, mem_wr_rq_o, loader_rd_ack_o, loader_wr_ack_o;
  logic        mem_loader_rd_ack_i, mem_loader_wr_ack_i;
  logic [7:0]  mem_loader_data_i, loader_rdata_o;
  logic [2:0]  key_sel_i;
  cpu_addr_t   ab_i;
  cpu_data_t   db_out_i, db_in_o, xram_data_i, vdp_data_i, xram_wdata_o;
  chip_sel_t   sel_o;
  xaddr_t      xaddr_o;
  loader_bus_t loader_i;
  key_row_t    ps2_row_i;
  int_pins_t   int_pins_o;

  logic [31:0] lfsr = 32'ha3ab_ca31;
  cart_page_t  exp_page;
  key_row_t    rows_model [8];
  logic        checking = 1'b0;
  logic        prev_rd, prev_wr;
  int          errors = 0;
  int          cycles = 0;

  tb_clock u_clk (.clk_o(clk));

  sys_glue #(.cart_base_p(cart_base)) DUT (.*);

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // Expected selects and external address from the memory map
  function automatic map_t ref_map(cpu_addr_t ab, logic rd, logic wr, cart_page_t page);
    map_t m;
    logic rw_area;
    m = '0;
    rw_area = (ab >= 16'h2000 && ab < 16'h4000) || (ab >= 16'h8000 && ab < 16'h8400) ||
              ab >= 16'ha000;
    m.sel.cart   = ab >= 16'h6000 && ab < 16'h8000;
    m.sel.xram   = rw_area || ((ab < 16'h2000 || m.sel.cart) && !wr);  // ROM and cart read only
    m.sel.vdp_rd = rd && ab[15:8] == 8'h88;
    m.sel.vdp_wr = wr && ab[15:8] == 8'h8c;
    m.sel.psi    = ab[15:8] == 8'h00;
    m.sel.aca    = ab[15:8] == 8'h01;
    if (m.sel.cart) begin
      m.xaddr = {cart_base, page, ab[12:1]};
    end else begin
      m.xaddr = {8'd0, ab[15:1]};
    end
    return m;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, want);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  // ------------------------------------------------------------------
  // CPU side compare, sampled mid-cycle
  // ------------------------------------------------------------------
  always @(negedge clk) begin
    map_t      want;
    cpu_data_t want_db;
    if (!checking || cpu_reset) begin
      prev_rd = 1'b0;
      prev_wr = 1'b0;
    end else begin
      want    = ref_map(ab_i, rd_i, wr_i, exp_page);
      want_db = want.sel.vdp_rd ? vdp_data_i : (want.sel.xram ? xram_data_i : '0);
      check_value("sel_o", 32'(sel_o), 32'(want.sel));
      check_value("xaddr_o", 32'(xaddr_o), 32'(want.xaddr));
      check_value("db_in_o", 32'(db_in_o), 32'(want_db));
      check_value("xram_wdata_o", 32'(xram_wdata_o), 32'(db_out_i));
      check_value("vdp_wr_o", 32'(vdp_wr_o), 32'(want.sel.vdp_wr && !prev_wr));  // First cycle
      check_value("mem_rd_rq_o", 32'(mem_rd_rq_o), 32'(rd_i && !prev_rd && want.sel.xram));
      check_value("mem_wr_rq_o", 32'(mem_wr_rq_o), 32'(wr_i && !prev_wr && want.sel.xram));
      prev_rd = rd_i;
      prev_wr = wr_i;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Timeout: run did not finish within %0d cycles", max_cycles);
      $display("Simulation FAILED");
      $fatal(1);
    end
  end

  // One CPU access held for hold cycles, then one idle cycle
  task automatic cpu_access(input cpu_addr_t ab, input logic is_wr, input int hold);
    logic [31:0] r;
    rand_bits(32, r);
    @(posedge clk);
    ab_i        <= ab;
    rd_i        <= !is_wr;
    wr_i        <= is_wr;
    vdp_data_i  <= r[31:16];
    xram_data_i <= r[15:0];
    db_out_i    <= r[23:8];
    @(posedge clk);
    if (is_wr && ab >= 16'h6000 && ab < 16'h8000) begin
      exp_page <= ab[8:1];  // Bank switch seen from the next cycle
    end
    repeat (hold - 1) @(posedge clk);
    rd_i <= 1'b0;
    wr_i <= 1'b0;
  endtask

  task automatic loader_write(input logic [31:0] addr, input logic [7:0] data);
    @(posedge clk);
    loader_i <= '{addr: addr, wdata: data, read_rq: 1'b0, write_rq: 1'b1};
    @(posedge clk);
    loader_i.write_rq <= 1'b0;
    @(negedge clk);
    check_value("loader_wr_ack_o", 32'(loader_wr_ack_o), 32'd1);
  endtask

  task automatic loader_read(input logic [31:0] addr, input logic [7:0] want);
    @(posedge clk);
    loader_i <= '{addr: addr, wdata: 8'h00, read_rq: 1'b1, write_rq: 1'b0};
    @(posedge clk);
    loader_i.read_rq <= 1'b0;
    @(negedge clk);
    check_value("loader_rd_ack_o", 32'(loader_rd_ack_o), 32'd1);
    check_value("loader_rdata_o", 32'(loader_rdata_o), 32'(want));
  endtask

  // acks order is vdp_wr, vdp_rd, mem_wr, mem_rd
  task automatic ready_case(input cpu_addr_t ab, input logic is_wr, input logic [3:0] acks,
                            input logic want);
    @(posedge clk);
    ab_i <= ab;
    rd_i <= !is_wr;
    wr_i <= is_wr;
    @(negedge clk);
    check_value("ready_o", 32'(ready_o), 32'd0);
    @(posedge clk);
    {vdp_wr_ack_i, vdp_rd_ack_i, mem_wr_ack_i, mem_rd_ack_i} <= acks;
    @(negedge clk);
    check_value("ready_o", 32'(ready_o), 32'(want));
    @(posedge clk);
    {vdp_wr_ack_i, vdp_rd_ack_i, mem_wr_ack_i, mem_rd_ack_i} <= 4'b0000;
    @(negedge clk);
    check_value("ready_o", 32'(ready_o), 32'(want));  // Held after the ack
    @(posedge clk);
    rd_i <= 1'b0;
    wr_i <= 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_value("ready_o", 32'(ready_o), 32'd0);
  endtask

  initial begin
    logic [31:0] r;
    logic [7:0]  ctrl;
    cpu_reset = 1'b1;
    ab_i = '0;
    db_out_i = '0;
    rd_i = 1'b0;
    wr_i = 1'b0;
    {mem_rd_ack_i, mem_wr_ack_i, vdp_rd_ack_i, vdp_wr_ack_i} = 4'b0000;
    {mem_loader_rd_ack_i, mem_loader_wr_ack_i} = 2'b00;
    xram_data_i = '0;
    vdp_data_i = '0;
    vdp_int_i = 1'b0;
    loader_i = '0;
    mem_loader_data_i = '0;
    ps2_row_i = '1;
    key_sel_i = '0;
    exp_page = '0;
    repeat (16) @(posedge clk);
    cpu_reset <= 1'b0;
    checking  <= 1'b1;

    // Random accesses over the whole map
    repeat (500) begin
      rand_bits(18, r);
      cpu_access(r[17:2], r[0], 1 + int'(r[1]));
    end

    // Bank switch, banked read, then reset clears the bank
    rand_bits(13, r);
    cpu_access({3'b011, r[12:0]}, 1'b1, 1);
    rand_bits(13, r);
    cpu_access({3'b011, r[12:0]}, 1'b0, 2);
    @(posedge clk);
    cpu_reset <= 1'b1;
    @(negedge clk);
    check_value("core_reset_o", 32'(core_reset_o), 32'd1);  // External reset reaches the core
    repeat (3) @(posedge clk);
    cpu_reset <= 1'b0;
    exp_page  <= '0;
    cpu_access({3'b011, r[12:0]}, 1'b0, 1);

    // ------------------------------------------------------------------
    // Keyboard rows and 9901 pins
    // ------------------------------------------------------------------
    for (int i = 0; i < 8; i++) begin
      rand_bits(8, r);
      rows_model[i] = r[7:0];
      loader_write(32'h0100_0000 | 32'(i), r[7:0]);
    end
    for (int i = 0; i < 8; i++) begin
      rand_bits(9, r);
      @(posedge clk);
      key_sel_i <= 3'(i);
      ps2_row_i <= r[7:0];
      vdp_int_i <= r[8];
      @(negedge clk);
      // Row register still holds the previous selection
      check_value("n_int3..n_int10", 32'(int_pins_o[9:2]),
                  32'(rows_model[i == 0 ? 0 : i - 1] & r[7:0]));
      @(posedge clk);
      @(negedge clk);
      check_value("n_int1", 32'(int_pins_o.n_int1), 32'd1);
      check_value("n_int2", 32'(int_pins_o.n_int2), 32'(!r[8]));
      check_value("n_int3..n_int10", 32'(int_pins_o[9:2]), 32'(rows_model[i] & r[7:0]));
    end
    for (int i = 0; i < 8; i++) begin
      loader_read(32'h0100_0000 | 32'(i), rows_model[i]);
    end

    // Reset control byte and unused register group
    loader_read(32'h0100_0008, 8'hff);
    rand_bits(8, r);
    ctrl = r[7:0] | 8'h01;
    loader_write(32'h0100_0008, ctrl);
    check_value("core_reset_o", 32'(core_reset_o), 32'd0);
    loader_read(32'h0100_0008, ctrl);
    loader_write(32'h0100_0008, ctrl & 8'hfe);
    check_value("core_reset_o", 32'(core_reset_o), 32'd1);
    loader_write(32'h0100_0008, 8'hff);
    check_value("core_reset_o", 32'(core_reset_o), 32'd0);
    loader_read(32'h0100_0010, 8'h00);

    // Memory-space acks and data pass through
    rand_bits(8, r);
    @(posedge clk);
    loader_i            <= '{addr: 32'h0000_1234, wdata: 8'h00, read_rq: 1'b0, write_rq: 1'b0};
    mem_loader_rd_ack_i <= 1'b1;
    mem_loader_data_i   <= r[7:0];
    @(negedge clk);
    check_value("loader_rd_ack_o", 32'(loader_rd_ack_o), 32'd1);
    check_value("loader_rdata_o", 32'(loader_rdata_o), 32'(r[7:0]));
    @(posedge clk);
    mem_loader_rd_ack_i <= 1'b0;
    mem_loader_wr_ack_i <= 1'b1;
    @(negedge clk);
    check_value("loader_wr_ack_o", 32'(loader_wr_ack_o), 32'd1);
    check_value("loader_rd_ack_o", 32'(loader_rd_ack_o), 32'd0);
    @(posedge clk);
    mem_loader_wr_ack_i <= 1'b0;

    // ------------------------------------------------------------------
    // CPU ready
    // ------------------------------------------------------------------
    rand_bits(13, r);
    ready_case({3'b001, r[12:0]}, 1'b0, 4'b0001, 1'b1);
    ready_case({3'b101, r[12:0]}, 1'b1, 4'b0010, 1'b1);
    ready_case(16'h8800, 1'b0, 4'b0100, 1'b1);
    ready_case(16'h8c00, 1'b1, 4'b1000, 1'b1);
    ready_case(16'h8800, 1'b0, 4'b0001, 1'b0);  // Memory ack on a VDP read
    ready_case({3'b000, r[12:0]}, 1'b1, 4'b0010, 1'b0);  // ROM write is not selected
    ready_case({3'b001, r[12:0]}, 1'b0, 4'b0100, 1'b0);

    repeat (2) @(posedge clk);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/sys_glue_assert.sv
/*
 * Concurrent timing checks on the glue top level: VDP write strobe
 * width, loader register acks and ready release, bound to sys_glue
 */
`default_nettype none

module sys_glue_assert (
  input logic                      clk,
  input logic                      cpu_reset,
  input logic                      rd_i,
  input logic                      wr_i,
  input logic                      ready_o,
  input logic                      vdp_wr_o,
  input logic                      reg_rd_ack,
  input logic                      reg_wr_ack,
  input sys_glue_pkg::loader_bus_t loader_i
);

  timeunit 1ns;
  timeprecision 100ps;

  import sys_glue_pkg::*;

  // ------------------------------------------------------------------
  // VDP write strobe lasts one cycle only
  // ------------------------------------------------------------------
  vdp_wr_single: assert property (@(posedge clk) disable iff (cpu_reset)
    vdp_wr_o |=> !vdp_wr_o)
    else $error("VDP write strobe held for two cycles");

  // Register acks follow a register-space request
  wr_ack_source: assert property (@(posedge clk) disable iff (cpu_reset)
    reg_wr_ack |-> $past(loader_i.write_rq && loader_i.addr[LOADER_REG_BIT]))
    else $error("Register write ack without a request");
  rd_ack_source: assert property (@(posedge clk) disable iff (cpu_reset)
    reg_rd_ack |-> $past(loader_i.read_rq && loader_i.addr[LOADER_REG_BIT]))
    else $error("Register read ack without a request");
  wr_ack_pulse: assert property (@(posedge clk) disable iff (cpu_reset)
    reg_wr_ack |=> !reg_wr_ack)
    else $error("Register write ack longer than one cycle");
  rd_ack_pulse: assert property (@(posedge clk) disable iff (cpu_reset)
    reg_rd_ack |=> !reg_rd_ack)
    else $error("Register read ack longer than one cycle");

  // Ready drops one cycle after the CPU ends its cycle
  ready_release: assert property (@(posedge clk) disable iff (cpu_reset)
    (!rd_i && !wr_i) |=> (!ready_o || rd_i || wr_i))
    else $error("Ready still high after the CPU cycle ended");

endmodule

bind sys_glue sys_glue_assert u_assert (
  .clk        (clk),
  .cpu_reset  (cpu_reset),
  .rd_i       (rd_i),
  .wr_i       (wr_i),
  .ready_o    (ready_o),
  .vdp_wr_o   (vdp_wr_o),
  .reg_rd_ack (reg_rd_ack),
  .reg_wr_ack (reg_wr_ack),
  .loader_i   (loader_i)
);

`default_nettype wire

// File: verification/tb_clock.sv
/*
 * Free-running testbench clock, 8 ns period by default
 */
`default_nettype none

module tb_clock #(
  parameter int half_period_p = 4
) (
  output logic clk_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(half_period_p) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// File: verilog/sys_glue.sv
/*
 * TI-99/4A glue logic top level: address decode, external memory
 * mapping, CPU ready and loader register space, with loader ack
 * merging and the core reset
 */
`default_nettype none

module sys_glue #(
  parameter logic [2:0] cart_base_p = sys_glue_pkg::CART_BASE_DEFAULT
) (
  input  logic                      clk,
  input  logic                      cpu_reset,
  // CPU bus
  input  sys_glue_pkg::cpu_addr_t   ab_i,
  input  sys_glue_pkg::cpu_data_t   db_out_i,
  input  logic                      rd_i,
  input  logic                      wr_i,
  output sys_glue_pkg::cpu_data_t   db_in_o,
  output logic                      ready_o,
  output sys_glue_pkg::chip_sel_t   sel_o,
  // External memory
  input  logic                      mem_rd_ack_i,
  input  logic                      mem_wr_ack_i,
  input  sys_glue_pkg::cpu_data_t   xram_data_i,
  output sys_glue_pkg::xaddr_t      xaddr_o,
  output sys_glue_pkg::cpu_data_t   xram_wdata_o,
  output logic                      mem_rd_rq_o,
  output logic                      mem_wr_rq_o,
  // VDP
  input  logic                      vdp_rd_ack_i,
  input  logic                      vdp_wr_ack_i,
  input  sys_glue_pkg::cpu_data_t   vdp_data_i,
  input  logic                      vdp_int_i,
  output logic                      vdp_wr_o,
  // Loader
  input  sys_glue_pkg::loader_bus_t loader_i,
  input  logic                      mem_loader_rd_ack_i,
  input  logic                      mem_loader_wr_ack_i,
  input  logic [7:0]                mem_loader_data_i,
  output logic [7:0]                loader_rdata_o,
  output logic                      loader_rd_ack_o,
  output logic                      loader_wr_ack_o,
  // Keyboard and 9901
  input  sys_glue_pkg::key_row_t    ps2_row_i,
  input  logic [2:0]                key_sel_i,
  output sys_glue_pkg::int_pins_t   int_pins_o,
  output logic                      core_reset_o
);

  import sys_glue_pkg::*;

  chip_sel_t  sel;
  logic       reg_rd_ack, reg_wr_ack;
  logic [7:0] reg_rdata;
  logic [7:0] reset_ctrl;

  cpu_bus_decode u_decode (
    .clk         (clk),
    .cpu_reset   (cpu_reset),
    .ab_i        (ab_i),
    .rd_i        (rd_i),
    .wr_i        (wr_i),
    .vdp_data_i  (vdp_data_i),
    .xram_data_i (xram_data_i),
    .sel_o       (sel),
    .vdp_wr_o    (vdp_wr_o),
    .db_in_o     (db_in_o)
  );

  xmem_map #(
    .cart_base_p (cart_base_p)
  ) u_xmem (
    .clk         (clk),
    .cpu_reset   (cpu_reset),
    .ab_i        (ab_i),
    .rd_i        (rd_i),
    .wr_i        (wr_i),
    .sel_i       (sel),
    .xaddr_o     (xaddr_o),
    .mem_rd_rq_o (mem_rd_rq_o),
    .mem_wr_rq_o (mem_wr_rq_o)
  );

  cpu_ready u_ready (
    .clk          (clk),
    .cpu_reset    (cpu_reset),
    .rd_i         (rd_i),
    .wr_i         (wr_i),
    .sel_i        (sel),
    .mem_rd_ack_i (mem_rd_ack_i),
    .mem_wr_ack_i (mem_wr_ack_i),
    .vdp_rd_ack_i (vdp_rd_ack_i),
    .vdp_wr_ack_i (vdp_wr_ack_i),
    .ready_o      (ready_o)
  );

  key_matrix u_keys (
    .clk          (clk),
    .cpu_reset    (cpu_reset),
    .loader_i     (loader_i),
    .key_sel_i    (key_sel_i),
    .ps2_row_i    (ps2_row_i),
    .vdp_int_i    (vdp_int_i),
    .reg_rd_ack_o (reg_rd_ack),
    .reg_wr_ack_o (reg_wr_ack),
    .reg_rdata_o  (reg_rdata),
    .reset_ctrl_o (reset_ctrl),
    .int_pins_o   (int_pins_o)
  );

  assign sel_o        = sel;
  assign xram_wdata_o = db_out_i;  // CPU write data to the memory controller

  //--------------------------------------------------------------------
  // Loader ack merge and read data select
  //--------------------------------------------------------------------
  assign loader_rd_ack_o = reg_rd_ack || mem_loader_rd_ack_i;
  assign loader_wr_ack_o = reg_wr_ack || mem_loader_wr_ack_i;
  assign loader_rdata_o  = loader_i.addr[LOADER_REG_BIT] ? reg_rdata : mem_loader_data_i;

  // External reset or loader-held reset
  assign core_reset_o = cpu_reset || !reset_ctrl[0];

endmodule

`default_nettype wire

// File: verilog/key_matrix.sv
/*
 * Loader register space: keyboard rows and CPU reset control byte
 * with read-back, and the 9901 input pin assembly
 */
`default_nettype none

module key_matrix (
  input  logic                      clk,
  input  logic                      cpu_reset,
  input  sys_glue_pkg::loader_bus_t loader_i,
  input  logic [2:0]                key_sel_i,
  input  sys_glue_pkg::key_row_t    ps2_row_i,
  input  logic                      vdp_int_i,
  output logic                      reg_rd_ack_o,
  output logic                      reg_wr_ack_o,
  output logic [7:0]                reg_rdata_o,
  output logic [7:0]                reset_ctrl_o,
  output sys_glue_pkg::int_pins_t   int_pins_o
);

  import sys_glue_pkg::*;

  key_row_t   rows [8];    // All keys up is FF
  key_row_t   key_line;    // Row picked by the 9901
  key_row_t   key_merged;
  logic [7:0] reset_ctrl;  // Bit 0 low holds the CPU in reset
  logic       reg_space;
  logic [1:0] reg_group;
  logic [2:0] row_idx;

  assign reg_space = loader_i.addr[LOADER_REG_BIT];
  assign reg_group = loader_i.addr[4:3];
  assign row_idx   = loader_i.addr[2:0];

  //--------------------------------------------------------------------
  // Loader writes and acks
  //--------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (cpu_reset) begin
      for (int i = 0; i < 8; i++) begin
        rows[i] <= '1;
      end
      reset_ctrl   <= 8'hff;
      reg_rd_ack_o <= 1'b0;
      reg_wr_ack_o <= 1'b0;
    end else begin
      reg_rd_ack_o <= 1'b0;
      reg_wr_ack_o <= 1'b0;
      if (loader_i.write_rq && reg_space) begin
        case (reg_group)
          2'd0:    rows[row_idx] <= loader_i.wdata;
          2'd1:    reset_ctrl    <= loader_i.wdata;
          default: ;                        // Acked, no storage
        endcase
        reg_wr_ack_o <= 1'b1;
      end else if (loader_i.read_rq && reg_space) begin
        reg_rd_ack_o <= 1'b1;
      end
    end
  end

  // Read-back data, held until the next read
  always_ff @(posedge clk) begin
    if (!loader_i.write_rq && loader_i.read_rq && reg_space) begin
      case (reg_group)
        2'd0:    reg_rdata_o <= rows[row_idx];
        2'd1:    reg_rdata_o <= reset_ctrl;
        default: reg_rdata_o <= 8'h00;
      endcase
    end
  end

  assign reset_ctrl_o = reset_ctrl;

  //--------------------------------------------------------------------
  // 9901 input pins
  //--------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (cpu_reset) begin
      key_line <= '1;
    end else begin
      key_line <= rows[key_sel_i];
    end
  end

  assign key_merged = key_line & ps2_row_i;  // Either source pulls a key low

  // n_int3..n_int10 carry row bits 0..7
  assign int_pins_o = {key_merged, ~vdp_int_i, 1'b1};

endmodule

`default_nettype wire

// File: verilog/cpu_ready.sv
/*
 * CPU ready: acks of the selected target, held until rd and wr drop
 */
`default_nettype none

module cpu_ready (
  input  logic                    clk,
  input  logic                    cpu_reset,
  input  logic                    rd_i,
  input  logic                    wr_i,
  input  sys_glue_pkg::chip_sel_t sel_i,
  input  logic                    mem_rd_ack_i,
  input  logic                    mem_wr_ack_i,
  input  logic                    vdp_rd_ack_i,
  input  logic                    vdp_wr_ack_i,
  output logic                    ready_o
);

  logic ready_now;
  logic keep_ready;

  // Only acks from the target of this cycle count
  assign ready_now = (sel_i.xram && (mem_rd_ack_i || mem_wr_ack_i)) ||
                     ((sel_i.vdp_rd || sel_i.vdp_wr) && (vdp_rd_ack_i || vdp_wr_ack_i));

  always_ff @(posedge clk) begin
    if (cpu_reset) begin
      keep_ready <= 1'b0;
    end else if (!rd_i && !wr_i) begin
      keep_ready <= 1'b0;  // CPU cycle over
    end else if (ready_now) begin
      keep_ready <= 1'b1;
    end
  end

  assign ready_o = ready_now || keep_ready;

endmodule

`default_nettype wire

// File: verilog/xmem_map.sv
/*
 * External memory mapping: cartridge bank register,
 * 23-bit external address and memory request pulses
 */
`default_nettype none

module xmem_map #(
  parameter logic [2:0] cart_base_p = sys_glue_pkg::CART_BASE_DEFAULT
) (
  input  logic                    clk,
  input  logic                    cpu_reset,
  input  sys_glue_pkg::cpu_addr_t ab_i,
  input  logic                    rd_i,
  input  logic                    wr_i,
  input  sys_glue_pkg::chip_sel_t sel_i,
  output sys_glue_pkg::xaddr_t    xaddr_o,
  output logic                    mem_rd_rq_o,
  output logic                    mem_wr_rq_o
);

  import sys_glue_pkg::*;

  logic       last_rd, last_wr;
  logic       rd_edge, wr_edge;
  cart_page_t cart_page;

  // Previous strobes for edge detection
  always_ff @(posedge clk) begin
    if (cpu_reset) begin
      last_rd <= 1'b0;
      last_wr <= 1'b0;
    end else begin
      last_rd <= rd_i;
      last_wr <= wr_i;
    end
  end

  assign rd_edge = rd_i && !last_rd;
  assign wr_edge = wr_i && !last_wr;

  assign mem_rd_rq_o = rd_edge && sel_i.xram;
  assign mem_wr_rq_o = wr_edge && sel_i.xram;

  //--------------------------------------------------------------------
  // Extended BASIC banking: the bank number comes from the address bus
  //--------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (cpu_reset) begin
      cart_page <= '0;
    end else if (wr_edge && sel_i.cart) begin
      cart_page <= ab_i[8:1];
    end
  end

  always_comb begin
    if (sel_i.cart) begin
      xaddr_o = {cart_base_p, cart_page, ab_i[12:1]};  // Banked window
    end else begin
      xaddr_o = {8'd0, ab_i[15:1]};                    // Flat CPU space
    end
  end

endmodule

`default_nettype wire

// File: verilog/cpu_bus_decode.sv
/*
 * CPU bus address decoder: chip selects with ROM and cartridge
 * write protection, one-cycle VDP write strobe, CPU read-data mux
 */
`default_nettype none

module cpu_bus_decode (
  input  logic                    clk,
  input  logic                    cpu_reset,
  input  sys_glue_pkg::cpu_addr_t ab_i,
  input  logic                    rd_i,
  input  logic                    wr_i,
  input  sys_glue_pkg::cpu_data_t vdp_data_i,
  input  sys_glue_pkg::cpu_data_t xram_data_i,
  output sys_glue_pkg::chip_sel_t sel_o,
  output logic                    vdp_wr_o,
  output sys_glue_pkg::cpu_data_t db_in_o
);

  import sys_glue_pkg::*;

  logic [7:0] page;
  logic       last_wr;
  logic       rom_area, ram_lo_area, cart_area, scratch_area, ram_hi_area;
  chip_sel_t  sel;

  assign page = ab_i[15:8];

  // Memory map regions
  assign rom_area     = ab_i[15:13] == 3'b000;            // 0000..1FFF
  assign ram_lo_area  = ab_i[15:13] == 3'b001;            // 2000..3FFF
  assign cart_area    = ab_i[15:13] == 3'b011;            // 6000..7FFF
  assign scratch_area = ab_i[15:10] == 6'b1000_00;        // 8000..83FF
  assign ram_hi_area  = ab_i[15:13] == 3'b101 || ab_i[15:14] == 2'b11;  // A000..FFFF

  always_comb begin
    sel.xram   = (rom_area && !wr_i) ||   // ROM is read only
                 ram_lo_area ||
                 (cart_area && !wr_i) ||  // Cartridge writes only switch banks
                 scratch_area ||
                 ram_hi_area;
    sel.vdp_rd = rd_i && page == PAGE_VDP_RD;
    sel.vdp_wr = wr_i && page == PAGE_VDP_WR;
    sel.psi    = page == PAGE_PSI;
    sel.aca    = page == PAGE_ACA;
    sel.cart   = cart_area;
  end

  assign sel_o = sel;

  always_ff @(posedge clk) begin
    if (cpu_reset) begin
      last_wr <= 1'b0;
    end else begin
      last_wr <= wr_i;
    end
  end

  // Strobe only on the rising edge of wr
  assign vdp_wr_o = sel.vdp_wr && !last_wr;

  assign db_in_o = sel.vdp_rd ? vdp_data_i  :
                   sel.xram   ? xram_data_i :
                                '0;

endmodule

`default_nettype wire

// File: verilog/sys_glue_pkg.sv
/*
 * Shared types and constants for the TI-99/4A glue logic:
 * bus widths, memory map pages, chip selects, loader bus and 9901 pins
 */
`default_nettype none

package sys_glue_pkg;

  //--------------------------------------------------------------------
  // Bus and register widths
  //--------------------------------------------------------------------
  typedef logic [15:0] cpu_addr_t;   // CPU word-byte address
  typedef logic [15:0] cpu_data_t;
  typedef logic [22:0] xaddr_t;      // External memory word address
  typedef logic [7:0]  cart_page_t;  // 256 banks of 8K
  typedef logic [7:0]  key_row_t;    // Active low, one bit per key

  //--------------------------------------------------------------------
  // Memory map constants
  //--------------------------------------------------------------------
  localparam logic [7:0] PAGE_PSI    = 8'h00;  // 9901 CRU page
  localparam logic [7:0] PAGE_ACA    = 8'h01;  // 9902 CRU page
  localparam logic [7:0] PAGE_VDP_RD = 8'h88;
  localparam logic [7:0] PAGE_VDP_WR = 8'h8c;

  localparam int         LOADER_REG_BIT    = 24;    // Loader register space
  localparam logic [2:0] CART_BASE_DEFAULT = 3'd1;  // Cartridge banks at 2M

  // Active-high chip selects for one CPU cycle
  typedef struct packed {
    logic xram;    // External memory
    logic vdp_rd;
    logic vdp_wr;
    logic psi;
    logic aca;
    logic cart;    // 6000..7FFF window
  } chip_sel_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [7:0]  wdata;
    logic        read_rq;
    logic        write_rq;
  } loader_bus_t;

  // 9901 interrupt and port inputs, all active low, n_int1 in bit 0
  typedef struct packed {
    logic n_int10;
    logic n_int9;
    logic n_int8;
    logic n_int7;
    logic n_int6;
    logic n_int5;
    logic n_int4;
    logic n_int3;
    logic n_int2;
    logic n_int1;
  } int_pins_t;

endpackage

`default_nettype wire
